// ==== fu_eov.f ====
+incdir+include
hdl/eov_pkg.sv
hdl/eov_ex5_if.sv
hdl/eov_exp_select.sv
hdl/eov_expo_adjust.sv
hdl/eov_range_flags.sv
hdl/fu_eov.sv
sim/fu_eov_chk.sv
sim/fu_eov_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the fu_eov testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
   --top-module fu_eov_tb \
   -f fu_eov.f \
   --Mdir obj_dir -o fu_eov_sim

./obj_dir/fu_eov_sim | tee sim.log

if grep -q '^>>> PASS$' sim.log; then
   echo "Simulation passed"
else
   echo "Simulation failed"
   exit 1
fi

// ==== sim/eov_cases.txt ====
// iexp tbe_expo tbe_may_ov sel_est sp_b lza sh_rgt no_edge extra tbl_unf oe ue ov_en uf_en sk_e sk_f sel_ov
// then expected: may_ovf p0 p1 ovf_expo ovf_if_expo unf_expo sel_k_f sel_kif_f sel_k_e sel_kif_e
0400 0000 0 0 1 05 0 0 0 0 0 0 1 1 0 0 0  0 03fb 03fc 0 0 0 0 0 0 0
0100 0000 0 0 1 10 1 0 1 0 0 0 0 0 0 0 0  0 01ef 01f0 0 0 0 0 0 0 0
0003 0000 0 0 1 20 0 0 0 0 0 0 0 1 0 0 0  0 1fe3 1fe4 0 0 1 0 0 1 1
0000 0500 1 1 1 00 0 0 0 0 0 0 0 0 0 0 0  1 0500 0501 0 0 0 0 0 0 0
042f 0000 1 0 1 00 0 0 0 0 0 0 0 0 0 0 0  0 042f 0430 0 0 0 0 0 0 0
0430 0000 0 0 1 00 0 0 0 0 0 0 0 0 0 0 0  1 0430 0431 0 0 0 0 0 0 0
07fe 0000 0 0 1 00 0 0 0 0 0 0 1 0 0 0 0  1 07fe 07ff 0 1 0 0 1 0 1
0800 0000 0 0 1 00 0 0 0 0 1 0 1 0 0 0 0  1 0800 0801 1 1 0 0 0 0 0
047f 0000 0 0 0 00 0 0 0 0 0 0 1 0 0 0 0  1 047f 0480 1 1 0 1 1 1 1
03ff 0000 0 0 1 00 0 0 0 0 0 0 0 0 0 1 1  0 03ff 0400 1 1 0 1 1 0 0
0380 0000 0 0 0 00 0 0 0 0 0 1 0 1 0 0 0  0 0380 0381 0 0 1 0 0 0 0
0005 0000 0 0 1 0a 0 1 0 1 0 0 0 1 0 0 0  0 1ffb 1ffc 0 0 1 0 0 1 1
0000 0300 0 1 0 00 0 0 0 0 0 0 0 1 0 0 0  0 0300 0301 0 0 1 0 0 0 0
03ff 0000 0 0 1 00 0 0 0 0 0 0 0 0 1 0 0  0 03ff 0400 0 0 0 0 0 1 1

// ==== sim/fu_eov_tb.sv ====
// Predictor pipeline testbench

`timescale 1ns/1ns
`default_nettype none

`include "eov_params.svh"

module fu_eov_tb;

   localparam int N_CASES = 14;
   localparam int N_FIELDS = 27;
   localparam int TIMEOUT = 100;

   logic [15:0] cases [0:N_CASES*N_FIELDS-1];

   logic                   nclk;
   logic                   reset;
   logic [`EOV_EXPO_W-1:0] f_eie_ex4_iexp;
   logic [`EOV_EXPO_W-1:0] f_tbe_ex4_expo;
   logic                   f_tbe_ex4_may_ov;
   logic                   f_pic_ex4_sel_est;
   logic                   f_pic_ex4_sp_b;
   logic [`EOV_LZA_W-1:0]  f_lza_ex5_lza_amt_eov;
   logic                   f_lza_ex5_sh_rgt_en_eov;
   logic                   f_lza_ex5_no_lza_edge;
   logic                   f_nrm_ex5_extra_shift;
   logic                   f_tbl_ex5_unf_expo;
   logic                   f_pic_ex5_oe;
   logic                   f_pic_ex5_ue;
   logic                   f_pic_ex5_ov_en;
   logic                   f_pic_ex5_uf_en;
   logic                   f_pic_ex5_spec_sel_k_e;
   logic                   f_pic_ex5_spec_sel_k_f;
   logic                   f_pic_ex5_sel_ov_spec;
   logic                   f_eov_ex5_may_ovf;
   logic                   f_eov_ex6_ovf_expo;
   logic                   f_eov_ex6_ovf_if_expo;
   logic                   f_eov_ex6_unf_expo;
   logic                   f_eov_ex6_sel_k_f;
   logic                   f_eov_ex6_sel_kif_f;
   logic                   f_eov_ex6_sel_k_e;
   logic                   f_eov_ex6_sel_kif_e;
   logic [`EOV_EXPO_W-1:0] f_eov_ex6_expo_p0;
   logic [`EOV_EXPO_W-1:0] f_eov_ex6_expo_p1;

   int checked;

   fu_eov dut (.*);

   always #2 nclk = ~nclk;

   task automatic compare(input string name, input logic [15:0] expected,
                          input logic [15:0] actual);
      if (expected !== actual) begin
         $display("FAILED %s expected %0h actual %0h", name, expected, actual);
         $display(">>> FAIL");
         $fatal(1);
      end
   endtask

   task automatic drive_ex4(input int idx);
      int b;
      b = idx * N_FIELDS;
      f_eie_ex4_iexp    = cases[b][`EOV_EXPO_W-1:0];
      f_tbe_ex4_expo    = cases[b+1][`EOV_EXPO_W-1:0];
      f_tbe_ex4_may_ov  = cases[b+2][0];
      f_pic_ex4_sel_est = cases[b+3][0];
      f_pic_ex4_sp_b    = cases[b+4][0];
   endtask

   task automatic drive_ex5(input int idx);
      int b;
      b = idx * N_FIELDS;
      f_lza_ex5_lza_amt_eov   = cases[b+5][`EOV_LZA_W-1:0];
      f_lza_ex5_sh_rgt_en_eov = cases[b+6][0];
      f_lza_ex5_no_lza_edge   = cases[b+7][0];
      f_nrm_ex5_extra_shift   = cases[b+8][0];
      f_tbl_ex5_unf_expo      = cases[b+9][0];
      f_pic_ex5_oe            = cases[b+10][0];
      f_pic_ex5_ue            = cases[b+11][0];
      f_pic_ex5_ov_en         = cases[b+12][0];
      f_pic_ex5_uf_en         = cases[b+13][0];
      f_pic_ex5_spec_sel_k_e  = cases[b+14][0];
      f_pic_ex5_spec_sel_k_f  = cases[b+15][0];
      f_pic_ex5_sel_ov_spec   = cases[b+16][0];
   endtask

   task automatic clear_ex4();
      f_eie_ex4_iexp    = '0;
      f_tbe_ex4_expo    = '0;
      f_tbe_ex4_may_ov  = 1'b0;
      f_pic_ex4_sel_est = 1'b0;
      f_pic_ex4_sp_b    = 1'b1;
   endtask

   task automatic clear_ex5();
      f_lza_ex5_lza_amt_eov   = '0;
      f_lza_ex5_sh_rgt_en_eov = 1'b0;
      f_lza_ex5_no_lza_edge   = 1'b0;
      f_nrm_ex5_extra_shift   = 1'b0;
      f_tbl_ex5_unf_expo      = 1'b0;
      f_pic_ex5_oe            = 1'b0;
      f_pic_ex5_ue            = 1'b0;
      f_pic_ex5_ov_en         = 1'b0;
      f_pic_ex5_uf_en         = 1'b0;
      f_pic_ex5_spec_sel_k_e  = 1'b0;
      f_pic_ex5_spec_sel_k_f  = 1'b0;
      f_pic_ex5_sel_ov_spec   = 1'b0;
   endtask

   task automatic check_ex5(input int idx);
      compare($sformatf("case %0d may_ovf", idx), cases[idx*N_FIELDS+17],
              {15'd0, f_eov_ex5_may_ovf});
   endtask

   task automatic check_ex6(input int idx);
      int b;
      b = idx * N_FIELDS;
      compare($sformatf("case %0d p0", idx), cases[b+18], {3'd0, f_eov_ex6_expo_p0});
      compare($sformatf("case %0d p1", idx), cases[b+19], {3'd0, f_eov_ex6_expo_p1});
      compare($sformatf("case %0d ovf_expo", idx), cases[b+20], {15'd0, f_eov_ex6_ovf_expo});
      compare($sformatf("case %0d ovf_if_expo", idx), cases[b+21],
              {15'd0, f_eov_ex6_ovf_if_expo});
      compare($sformatf("case %0d unf_expo", idx), cases[b+22], {15'd0, f_eov_ex6_unf_expo});
      compare($sformatf("case %0d sel_k_f", idx), cases[b+23], {15'd0, f_eov_ex6_sel_k_f});
      compare($sformatf("case %0d sel_kif_f", idx), cases[b+24], {15'd0, f_eov_ex6_sel_kif_f});
      compare($sformatf("case %0d sel_k_e", idx), cases[b+25], {15'd0, f_eov_ex6_sel_k_e});
      compare($sformatf("case %0d sel_kif_e", idx), cases[b+26], {15'd0, f_eov_ex6_sel_kif_e});
      checked++;
   endtask

   // Everything reads zero while the registers sit in reset
   task automatic check_idle();
      compare("reset may_ovf", 16'd0, {15'd0, f_eov_ex5_may_ovf});
      compare("reset p0", 16'd0, {3'd0, f_eov_ex6_expo_p0});
      compare("reset p1", 16'd0, {3'd0, f_eov_ex6_expo_p1});
      compare("reset flags", 16'd0, {9'd0, f_eov_ex6_ovf_expo, f_eov_ex6_ovf_if_expo,
              f_eov_ex6_unf_expo, f_eov_ex6_sel_k_f, f_eov_ex6_sel_kif_f,
              f_eov_ex6_sel_k_e, f_eov_ex6_sel_kif_e});
   endtask

   initial begin
      nclk  = 1'b0;
      reset = 1'b1;
      clear_ex4();
      clear_ex5();
      repeat (5) @(posedge nclk);
      #1 reset = 1'b0;
   end

   initial begin
      int cycles;
      checked = 0;
      $readmemh("sim/eov_cases.txt", cases);

      cycles = 0;
      forever begin
         @(posedge nclk);
         if (!reset) break;
         #1 check_idle();
         cycles++;
         if (cycles > TIMEOUT) begin
            $display("Timed out waiting for reset to be released");
            $display(">>> FAIL");
            $fatal(1);
         end
      end
      #1;

      // A case's ex4 inputs go in one cycle ahead of its ex5 inputs
      for (int k = 0; k < N_CASES + 1; k++) begin
         @(posedge nclk);
         #1;
         if (k >= 1 && k <= N_CASES) check_ex5(k - 1);
         if (k >= 2) check_ex6(k - 2);
         if (k < N_CASES) drive_ex4(k);
         else clear_ex4();
         if (k >= 1 && k <= N_CASES) drive_ex5(k - 1);
         else clear_ex5();
      end

      // The last case still sits in ex6 once all inputs are in
      cycles = 0;
      while (checked < N_CASES) begin
         @(posedge nclk);
         #1 check_ex6(checked);
         cycles++;
         if (cycles > TIMEOUT) begin
            $display("Timed out waiting for the last cases to leave the pipeline");
            $display(">>> FAIL");
            $fatal(1);
         end
      end

      $display(">>> PASS");
      $finish;
   end

endmodule

`default_nettype wire

// ==== sim/fu_eov_chk.sv ====
// Predictor pipeline assertions

`timescale 1ns/1ns
`default_nettype none

module fu_eov_chk (
   input wire        nclk,
   input wire        reset,
   input wire        sel_ov_spec,
   input wire        ovf_expo,
   input wire [6:0]  ex6_flags,
   input wire [12:0] expo_p0,
   input wire [12:0] expo_p1
);

   // The rounding-carry exponent is always one above the plain one
   p1_above_p0: assert property (@(posedge nclk) disable iff (reset)
      $past(!reset) |-> expo_p1 == expo_p0 + 13'd1)
      else $error("ex6 p1 is not p0 plus one");

   spec_forces_ovf: assert property (@(posedge nclk) disable iff (reset)
      sel_ov_spec |=> ovf_expo)
      else $error("sel_ov_spec did not raise ovf_expo");

   flags_clear_after_reset: assert property (@(posedge nclk)
      reset |=> ex6_flags == 7'd0)
      else $error("ex6 flags not cleared by reset");

endmodule

bind fu_eov fu_eov_chk u_chk (
   .nclk        (nclk),
   .reset       (reset),
   .sel_ov_spec (f_pic_ex5_sel_ov_spec),
   .ovf_expo    (f_eov_ex6_ovf_expo),
   .ex6_flags   ({f_eov_ex6_ovf_expo, f_eov_ex6_ovf_if_expo, f_eov_ex6_unf_expo,
                  f_eov_ex6_sel_k_f, f_eov_ex6_sel_kif_f, f_eov_ex6_sel_k_e,
                  f_eov_ex6_sel_kif_e}),
   .expo_p0     (f_eov_ex6_expo_p0),
   .expo_p1     (f_eov_ex6_expo_p1)
);

`default_nettype wire

// ==== hdl/fu_eov.sv ====
// Exponent overflow and underflow predictor

`timescale 1ns/1ns
`default_nettype none

`include "eov_params.svh"

module fu_eov (
   input  logic                    nclk,
   input  logic                    reset,
   input  logic [`EOV_EXPO_W-1:0] f_eie_ex4_iexp,
   input  logic [`EOV_EXPO_W-1:0] f_tbe_ex4_expo,
   input  logic                    f_tbe_ex4_may_ov,
   input  logic                    f_pic_ex4_sel_est,
   input  logic                    f_pic_ex4_sp_b,
   input  logic [`EOV_LZA_W-1:0]  f_lza_ex5_lza_amt_eov,
   input  logic                    f_lza_ex5_sh_rgt_en_eov,
   input  logic                    f_lza_ex5_no_lza_edge,
   input  logic                    f_nrm_ex5_extra_shift,
   input  logic                    f_tbl_ex5_unf_expo,
   input  logic                    f_pic_ex5_oe,
   input  logic                    f_pic_ex5_ue,
   input  logic                    f_pic_ex5_ov_en,
   input  logic                    f_pic_ex5_uf_en,
   input  logic                    f_pic_ex5_spec_sel_k_e,
   input  logic                    f_pic_ex5_spec_sel_k_f,
   input  logic                    f_pic_ex5_sel_ov_spec,
   output logic                    f_eov_ex5_may_ovf,
   output logic                    f_eov_ex6_ovf_expo,
   output logic                    f_eov_ex6_ovf_if_expo,
   output logic                    f_eov_ex6_unf_expo,
   output logic                    f_eov_ex6_sel_k_f,
   output logic                    f_eov_ex6_sel_kif_f,
   output logic                    f_eov_ex6_sel_k_e,
   output logic                    f_eov_ex6_sel_kif_e,
   output logic [`EOV_EXPO_W-1:0] f_eov_ex6_expo_p0,
   output logic [`EOV_EXPO_W-1:0] f_eov_ex6_expo_p1
);

   eov_pkg::expo_u ex5_expo_p0;
   eov_pkg::expo_u ex5_expo_p1;

   eov_ex5_if ex5_bus ();

   eov_exp_select u_exp_select (
      .nclk              (nclk),
      .reset             (reset),
      .f_eie_ex4_iexp    (f_eie_ex4_iexp),
      .f_tbe_ex4_expo    (f_tbe_ex4_expo),
      .f_tbe_ex4_may_ov  (f_tbe_ex4_may_ov),
      .f_pic_ex4_sel_est (f_pic_ex4_sel_est),
      .f_pic_ex4_sp_b    (f_pic_ex4_sp_b),
      .ex5               (ex5_bus.stage)
   );

   assign f_eov_ex5_may_ovf = ex5_bus.may_ovf;

   eov_expo_adjust u_expo_adjust (
      .nclk                    (nclk),
      .reset                   (reset),
      .ex5                     (ex5_bus.use_ex5),
      .f_lza_ex5_lza_amt_eov   (f_lza_ex5_lza_amt_eov),
      .f_lza_ex5_sh_rgt_en_eov (f_lza_ex5_sh_rgt_en_eov),
      .f_nrm_ex5_extra_shift   (f_nrm_ex5_extra_shift),
      .ex5_expo_p0             (ex5_expo_p0),
      .ex5_expo_p1             (ex5_expo_p1),
      .f_eov_ex6_expo_p0       (f_eov_ex6_expo_p0),
      .f_eov_ex6_expo_p1       (f_eov_ex6_expo_p1)
   );

   eov_range_flags u_range_flags (
      .nclk                   (nclk),
      .reset                  (reset),
      .ex5                    (ex5_bus.use_ex5),
      .ex5_expo_p0            (ex5_expo_p0),
      .ex5_expo_p1            (ex5_expo_p1),
      .f_tbl_ex5_unf_expo     (f_tbl_ex5_unf_expo),
      .f_pic_ex5_oe           (f_pic_ex5_oe),
      .f_pic_ex5_ue           (f_pic_ex5_ue),
      .f_pic_ex5_ov_en        (f_pic_ex5_ov_en),
      .f_pic_ex5_uf_en        (f_pic_ex5_uf_en),
      .f_pic_ex5_spec_sel_k_e (f_pic_ex5_spec_sel_k_e),
      .f_pic_ex5_spec_sel_k_f (f_pic_ex5_spec_sel_k_f),
      .f_pic_ex5_sel_ov_spec  (f_pic_ex5_sel_ov_spec),
      .f_lza_ex5_no_lza_edge  (f_lza_ex5_no_lza_edge),
      .f_eov_ex6_ovf_expo     (f_eov_ex6_ovf_expo),
      .f_eov_ex6_ovf_if_expo  (f_eov_ex6_ovf_if_expo),
      .f_eov_ex6_unf_expo     (f_eov_ex6_unf_expo),
      .f_eov_ex6_sel_k_f      (f_eov_ex6_sel_k_f),
      .f_eov_ex6_sel_kif_f    (f_eov_ex6_sel_kif_f),
      .f_eov_ex6_sel_k_e      (f_eov_ex6_sel_k_e),
      .f_eov_ex6_sel_kif_e    (f_eov_ex6_sel_kif_e)
   );

endmodule

`default_nettype wire

// ==== hdl/eov_range_flags.sv ====
// Ex5 range checks and ex6 flags

`timescale 1ns/1ns
`default_nettype none

`include "eov_params.svh"

module eov_range_flags (
   input  logic           nclk,
   input  logic           reset,
   eov_ex5_if.use_ex5     ex5,
   input  eov_pkg::expo_u ex5_expo_p0,
   input  eov_pkg::expo_u ex5_expo_p1,
   input  logic           f_tbl_ex5_unf_expo,
   input  logic           f_pic_ex5_oe,
   input  logic           f_pic_ex5_ue,
   input  logic           f_pic_ex5_ov_en,
   input  logic           f_pic_ex5_uf_en,
   input  logic           f_pic_ex5_spec_sel_k_e,
   input  logic           f_pic_ex5_spec_sel_k_f,
   input  logic           f_pic_ex5_sel_ov_spec,
   input  logic           f_lza_ex5_no_lza_edge,
   output logic           f_eov_ex6_ovf_expo,
   output logic           f_eov_ex6_ovf_if_expo,
   output logic           f_eov_ex6_unf_expo,
   output logic           f_eov_ex6_sel_k_f,
   output logic           f_eov_ex6_sel_kif_f,
   output logic           f_eov_ex6_sel_k_e,
   output logic           f_eov_ex6_sel_kif_e
);

   logic signed [`EOV_EXPO_W-1:0] ovf_limit;
   logic signed [`EOV_EXPO_W-1:0] unf_limit;

   logic ex5_ovf;
   logic ex5_ovf_if;
   logic ex5_unf;
   logic ex5_est_sp;
   logic ex5_ov_en_oe0;
   logic ex5_unf_en_nedge;
   logic ex5_unf_ue0_nestsp;
   logic ex5_unf_tbl;
   logic ex5_unf_tbl_spec_e;

   logic ex6_ovf;
   logic ex6_ovf_if;
   logic ex6_unf;
   logic ex6_ov_en;
   logic ex6_ov_en_oe0;
   logic ex6_unf_en_nedge;
   logic ex6_unf_ue0_nestsp;
   logic ex6_unf_tbl;
   logic ex6_unf_tbl_spec_e;
   logic ex6_sel_k_part_f;
   logic ex6_sel_ov_spec;

   assign ovf_limit = ex5.sp ? `EOV_SP_OVF_LIMIT : `EOV_DP_OVF_LIMIT;
   assign unf_limit = ex5.sp ? `EOV_SP_UNF_LIMIT : `EOV_DP_UNF_LIMIT;

   // p0 is the exponent without rounding carry, p1 the one with it
   assign ex5_ovf    = ex5_expo_p0.value >= ovf_limit;
   assign ex5_ovf_if = ex5_expo_p1.value >= ovf_limit;
   assign ex5_unf    = ex5_expo_p0.value <= unf_limit;

   // Single precision estimates keep their own denormal handling
   assign ex5_est_sp = ex5.sel_est & ex5.sp;

   assign ex5_ov_en_oe0      = f_pic_ex5_ov_en & ~f_pic_ex5_oe;
   assign ex5_unf_en_nedge   = f_pic_ex5_uf_en & ~f_lza_ex5_no_lza_edge;
   assign ex5_unf_ue0_nestsp = ex5_unf_en_nedge & ~f_pic_ex5_ue & ~ex5_est_sp;
   assign ex5_unf_tbl        = f_pic_ex5_uf_en & f_tbl_ex5_unf_expo;
   assign ex5_unf_tbl_spec_e = (ex5_unf_tbl & ~f_pic_ex5_ue & ~ex5_est_sp) |
                               f_pic_ex5_spec_sel_k_e;

   always_ff @(posedge nclk) begin
      if (reset) begin
         ex6_ovf            <= 1'b0;
         ex6_ovf_if         <= 1'b0;
         ex6_unf            <= 1'b0;
         ex6_ov_en          <= 1'b0;
         ex6_ov_en_oe0      <= 1'b0;
         ex6_unf_en_nedge   <= 1'b0;
         ex6_unf_ue0_nestsp <= 1'b0;
         ex6_unf_tbl        <= 1'b0;
         ex6_unf_tbl_spec_e <= 1'b0;
         ex6_sel_k_part_f   <= 1'b0;
         ex6_sel_ov_spec    <= 1'b0;
      end else begin
         ex6_ovf            <= ex5_ovf;
         ex6_ovf_if         <= ex5_ovf_if;
         ex6_unf            <= ex5_unf;
         ex6_ov_en          <= f_pic_ex5_ov_en;
         ex6_ov_en_oe0      <= ex5_ov_en_oe0;
         ex6_unf_en_nedge   <= ex5_unf_en_nedge;
         ex6_unf_ue0_nestsp <= ex5_unf_ue0_nestsp;
         ex6_unf_tbl        <= ex5_unf_tbl;
         ex6_unf_tbl_spec_e <= ex5_unf_tbl_spec_e;
         ex6_sel_k_part_f   <= f_pic_ex5_spec_sel_k_f;
         ex6_sel_ov_spec    <= f_pic_ex5_sel_ov_spec;
      end
   end

   assign f_eov_ex6_ovf_expo    = (ex6_ovf & ex6_ov_en) | ex6_sel_ov_spec;
   assign f_eov_ex6_ovf_if_expo = (ex6_ovf_if & ex6_ov_en) | ex6_sel_ov_spec;

   // With the trap disabled the fraction is forced to its k value
   assign f_eov_ex6_sel_k_f   = (ex6_ovf & ex6_ov_en_oe0) | ex6_sel_k_part_f;
   assign f_eov_ex6_sel_kif_f = (ex6_ovf_if & ex6_ov_en_oe0) | ex6_sel_k_part_f;

   assign f_eov_ex6_unf_expo = (ex6_unf & ex6_unf_en_nedge) | ex6_unf_tbl;

   assign f_eov_ex6_sel_k_e   = (ex6_unf & ex6_unf_ue0_nestsp) | ex6_unf_tbl_spec_e |
                                (ex6_ovf & ex6_ov_en_oe0);
   assign f_eov_ex6_sel_kif_e = (ex6_unf & ex6_unf_ue0_nestsp) | ex6_unf_tbl_spec_e |
                                (ex6_ovf_if & ex6_ov_en_oe0);

endmodule

`default_nettype wire

// ==== hdl/eov_expo_adjust.sv ====
// Ex5 exponent adjust

`timescale 1ns/1ns
`default_nettype none

`include "eov_params.svh"

module eov_expo_adjust (
   input  logic                   nclk,
   input  logic                   reset,
   eov_ex5_if.use_ex5             ex5,
   input  logic [`EOV_LZA_W-1:0] f_lza_ex5_lza_amt_eov,
   input  logic                   f_lza_ex5_sh_rgt_en_eov,
   input  logic                   f_nrm_ex5_extra_shift,
   output eov_pkg::expo_u         ex5_expo_p0,
   output eov_pkg::expo_u         ex5_expo_p1,
   output eov_pkg::expo_u         f_eov_ex6_expo_p0,
   output eov_pkg::expo_u         f_eov_ex6_expo_p1
);

   eov_pkg::expo_u         sh_amt;
   logic [`EOV_EXPO_W-1:0] extra;

   // A right shift makes the amount negative, so the upper field fills with ones
   always_comb begin
      sh_amt.parts.lo = f_lza_ex5_lza_amt_eov;
      sh_amt.parts.hi = {`EOV_HI_W{f_lza_ex5_sh_rgt_en_eov}};
   end

   assign extra = {{(`EOV_EXPO_W-1){1'b0}}, f_nrm_ex5_extra_shift};

   // The extra shift moves the binary point one more place, p1 covers rounding carry-out
   always_comb begin
      ex5_expo_p0.value = ex5.iexp.value - sh_amt.value - extra;
      ex5_expo_p1.value = ex5_expo_p0.value + 1'b1;
   end

   always_ff @(posedge nclk) begin
      if (reset) begin
         f_eov_ex6_expo_p0 <= '0;
         f_eov_ex6_expo_p1 <= '0;
      end else begin
         f_eov_ex6_expo_p0 <= ex5_expo_p0;
         f_eov_ex6_expo_p1 <= ex5_expo_p1;
      end
   end

endmodule

`default_nettype wire

// ==== hdl/eov_exp_select.sv ====
// Ex4 exponent select

`timescale 1ns/1ns
`default_nettype none

`include "eov_params.svh"

module eov_exp_select (
   input  logic                    nclk,
   input  logic                    reset,
   input  logic [`EOV_EXPO_W-1:0] f_eie_ex4_iexp,
   input  logic [`EOV_EXPO_W-1:0] f_tbe_ex4_expo,
   input  logic                    f_tbe_ex4_may_ov,
   input  logic                    f_pic_ex4_sel_est,
   input  logic                    f_pic_ex4_sp_b,
   eov_ex5_if.stage                ex5
);

   logic [`EOV_EXPO_W-1:0] ex4_iexp;
   logic                   ex4_may_ov_usual;
   logic                   ex4_may_ovf;

   // Estimate instructions take their exponent from the table
   assign ex4_iexp = f_pic_ex4_sel_est ? f_tbe_ex4_expo : f_eie_ex4_iexp;

   // Negative exponents can never get near the overflow range
   assign ex4_may_ov_usual = $signed(f_eie_ex4_iexp) >= `EOV_MAY_OVF_LIMIT;

   assign ex4_may_ovf = f_pic_ex4_sel_est ? f_tbe_ex4_may_ov : ex4_may_ov_usual;

   always_ff @(posedge nclk) begin
      if (reset) begin
         ex5.iexp    <= '0;
         ex5.sp      <= 1'b0;
         ex5.sel_est <= 1'b0;
         ex5.may_ovf <= 1'b0;
      end else begin
         ex5.iexp    <= ex4_iexp;
         ex5.sp      <= ~f_pic_ex4_sp_b;
         ex5.sel_est <= f_pic_ex4_sel_est;
         ex5.may_ovf <= ex4_may_ovf;
      end
   end

endmodule

`default_nettype wire

// ==== hdl/eov_ex5_if.sv ====
// Ex5 exponent bundle

`timescale 1ns/1ns
`default_nettype none

interface eov_ex5_if;

   eov_pkg::expo_u iexp;
   logic           sp;
   logic           sel_est;
   logic           may_ovf;

   // Driven by the ex4 select stage
   modport stage (
      output iexp,
      output sp,
      output sel_est,
      output may_ovf
   );

   // Read by the ex5 adjust and range stages
   modport use_ex5 (
      input iexp,
      input sp,
      input sel_est,
      input may_ovf
   );

endinterface

`default_nettype wire

// ==== hdl/eov_pkg.sv ====
// Exponent predictor types

`default_nettype none

`include "eov_params.svh"

package eov_pkg;

   // Shift field layout of an exponent word
   typedef struct packed {
      logic [`EOV_HI_W-1:0]  hi;
      logic [`EOV_LZA_W-1:0] lo;
   } expo_parts_t;

   // Read as a signed exponent or split around the shift field
   typedef union packed {
      logic signed [`EOV_EXPO_W-1:0] value;
      expo_parts_t                   parts;
   } expo_u;

endpackage

`default_nettype wire

// ==== include/eov_params.svh ====
// Exponent predictor widths and limits

`ifndef EOV_PARAMS_SVH
`define EOV_PARAMS_SVH

// Intermediate exponent, signed two's complement with bias 1023
`define EOV_EXPO_W 13

// Normalizer shift amount and the exponent bits above it
`define EOV_LZA_W 8
`define EOV_HI_W 5

// Smallest internal exponents that overflow
`define EOV_DP_OVF_LIMIT 2047
`define EOV_SP_OVF_LIMIT 1151

// Largest internal exponents that underflow
`define EOV_DP_UNF_LIMIT 0
`define EOV_SP_UNF_LIMIT 896

// Early warning threshold seen at ex4
`define EOV_MAY_OVF_LIMIT 1072

`endif
